// ==== hdl/soc_consts.svh ====
// --------------------------------------------------
// widths, icache geometry and timer addresses
// all data words are 64 bits; writes are full words
// timer registers sit at fixed CLINT-style addresses
// --------------------------------------------------

`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// datapath widths
`define SOC_ADDR_W 64
`define SOC_DATA_W 64
`define SOC_INST_W 32

// icache geometry, one 32-bit instruction per entry
`define SOC_ICACHE_INDEX_W  6
`define SOC_ICACHE_OFFSET_W 2

// tag width for the default geometry
`define SOC_ICACHE_TAG_W (`SOC_ADDR_W - `SOC_ICACHE_INDEX_W - `SOC_ICACHE_OFFSET_W)

// machine timer registers
`define SOC_MTIME_ADDR    64'h0200_bff8
`define SOC_MTIMECMP_ADDR 64'h0200_4000

`endif

// ==== hdl/soc_pkg.sv ====
// --------------------------------------------------
// shared address types for the memory subsystem
// field layout follows the default icache geometry
// --------------------------------------------------

`include "soc_consts.svh"

package soc_pkg;

    // byte address on every port
    typedef logic [`SOC_ADDR_W-1:0] soc_addr_t;

    // fetch address split for the direct-mapped lookup
    typedef struct packed {
        logic [`SOC_ICACHE_TAG_W-1:0]    tag;
        logic [`SOC_ICACHE_INDEX_W-1:0]  index;
        logic [`SOC_ICACHE_OFFSET_W-1:0] offset;
    } icache_addr_fields_t;

    // same fetch word, seen as a RAM address or as cache fields
    typedef union packed {
        soc_addr_t           raw;
        icache_addr_fields_t f;
    } icache_addr_u;

endpackage

// ==== hdl/icache.sv ====
// --------------------------------------------------
// direct-mapped icache, one instruction per entry
// requester holds i_inst_ena and address until valid
// hit answers next cycle, miss after the refill ok
// --------------------------------------------------

`include "soc_consts.svh"

module icache #(
    parameter int INDEX_W = `SOC_ICACHE_INDEX_W
) (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_inst_ena,
    input  soc_pkg::icache_addr_u  i_inst_addr,
    input  logic                   i_refill_ok,
    input  logic [`SOC_INST_W-1:0] i_refill_data,
    output logic [`SOC_INST_W-1:0] o_inst,
    output logic                   o_inst_valid,
    output logic                   o_refill_req,
    output soc_pkg::soc_addr_t     o_refill_addr
);
    import soc_pkg::*;

    // word address above the byte offset, split again for any INDEX_W
    localparam int LINE_W = $bits(icache_addr_fields_t) - `SOC_ICACHE_OFFSET_W;
    localparam int TAG_W  = LINE_W - INDEX_W;
    localparam int DEPTH  = 1 << INDEX_W;

    logic [TAG_W-1:0]       tag_mem  [DEPTH];
    logic [`SOC_INST_W-1:0] data_mem [DEPTH];
    logic [DEPTH-1:0]       valid_q;

    logic [LINE_W-1:0]  line_addr;
    logic [INDEX_W-1:0] idx;
    logic [TAG_W-1:0]   tag;
    logic               hit;
    logic               refill_q;

    assign line_addr = {i_inst_addr.f.tag, i_inst_addr.f.index};
    assign idx       = line_addr[INDEX_W-1:0];
    assign tag       = line_addr[LINE_W-1:INDEX_W];
    assign hit       = valid_q[idx] && (tag_mem[idx] == tag);

    assign o_refill_req  = refill_q;
    assign o_refill_addr = i_inst_addr.raw;

    // lookup and refill control
    always_ff @(posedge clk) begin
        if (i_reset) begin
            refill_q     <= 1'b0;
            o_inst_valid <= 1'b0;
            valid_q      <= '0;
        end else begin
            o_inst_valid <= 1'b0;
            if (refill_q) begin
                if (i_refill_ok) begin
                    refill_q     <= 1'b0;
                    o_inst_valid <= 1'b1;
                    valid_q[idx] <= 1'b1;
                end
            end else if (i_inst_ena && !o_inst_valid) begin
                // valid pulse blocks the still-held request
                if (hit) begin
                    o_inst_valid <= 1'b1;
                end else begin
                    refill_q <= 1'b1;
                end
            end
        end
    end

    // arrays and returned word
    always_ff @(posedge clk) begin
        if (refill_q) begin
            if (i_refill_ok) begin
                tag_mem[idx]  <= tag;
                data_mem[idx] <= i_refill_data;
                o_inst        <= i_refill_data;
            end
        end else begin
            o_inst <= data_mem[idx];
        end
    end

endmodule

// ==== hdl/dmem_router.sv ====
// --------------------------------------------------
// splits data accesses between RAM and the timer
// only exact mtime/mtimecmp addresses hit the timer
// requester holds its level until o_mem_finish
// --------------------------------------------------

`include "soc_consts.svh"

module dmem_router (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_data_re,
    input  logic                   i_data_we,
    input  soc_pkg::soc_addr_t     i_data_addr,
    input  logic [`SOC_DATA_W-1:0] i_data_wdata,
    input  logic                   i_ram_ok,
    input  logic [`SOC_DATA_W-1:0] i_ram_rdata,
    input  logic [`SOC_DATA_W-1:0] i_tmr_rdata,
    output logic                   o_ram_re,
    output logic                   o_ram_we,
    output soc_pkg::soc_addr_t     o_ram_addr,
    output logic [`SOC_DATA_W-1:0] o_ram_wdata,
    output logic                   o_tmr_we,
    output logic                   o_tmr_sel,
    output logic [`SOC_DATA_W-1:0] o_tmr_wdata,
    output logic [`SOC_DATA_W-1:0] o_data_rdata,
    output logic                   o_mem_finish
);

    logic is_mtimecmp;
    logic is_tmr;
    logic tmr_access;
    // high in the finish cycle, while the old request is still held
    logic busy;

    assign is_mtimecmp = (i_data_addr == `SOC_MTIMECMP_ADDR);
    assign is_tmr      = is_mtimecmp || (i_data_addr == `SOC_MTIME_ADDR);
    assign tmr_access  = (i_data_re || i_data_we) && is_tmr && !busy;

    assign o_tmr_sel   = is_mtimecmp;
    assign o_tmr_we    = i_data_we && is_tmr && !busy;
    assign o_tmr_wdata = i_data_wdata;

    assign o_ram_re    = i_data_re && !is_tmr && !busy;
    assign o_ram_we    = i_data_we && !is_tmr && !busy;
    assign o_ram_addr  = i_data_addr;
    assign o_ram_wdata = i_data_wdata;

    assign o_mem_finish = busy;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            busy <= 1'b0;
        end else begin
            busy <= tmr_access || i_ram_ok;
        end
    end

    // read data, timer value taken in the request cycle
    always_ff @(posedge clk) begin
        o_data_rdata <= tmr_access ? i_tmr_rdata : i_ram_rdata;
    end

endmodule

// ==== hdl/clint_timer.sv ====
// --------------------------------------------------
// mtime counts every clock, no prescaler
// interrupt stays high while mtime >= mtimecmp
// --------------------------------------------------

`include "soc_consts.svh"

module clint_timer (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_tmr_we,
    input  logic                   i_tmr_sel,
    input  logic [`SOC_DATA_W-1:0] i_tmr_wdata,
    output logic [`SOC_DATA_W-1:0] o_tmr_rdata,
    output logic                   o_timer_intr
);

    logic [`SOC_DATA_W-1:0] mtime_q;
    logic [`SOC_DATA_W-1:0] mtimecmp_q;

    // sel high picks mtimecmp
    assign o_tmr_rdata = i_tmr_sel ? mtimecmp_q : mtime_q;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            mtime_q      <= '0;
            mtimecmp_q   <= '1;
            o_timer_intr <= 1'b0;
        end else begin
            if (i_tmr_we && !i_tmr_sel) begin
                mtime_q <= i_tmr_wdata;
            end else begin
                mtime_q <= mtime_q + 1'b1;
            end
            if (i_tmr_we && i_tmr_sel) begin
                mtimecmp_q <= i_tmr_wdata;
            end
            o_timer_intr <= (mtime_q >= mtimecmp_q);
        end
    end

endmodule

// ==== hdl/mem_arbiter.sv ====
// --------------------------------------------------
// single external RAM port, data side has priority
// fixed latency RAM: read data one cycle after enable
// one access in flight, back to idle after each
// --------------------------------------------------

`include "soc_consts.svh"

module mem_arbiter (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_data_re,
    input  logic                   i_data_we,
    input  soc_pkg::soc_addr_t     i_data_addr,
    input  logic [`SOC_DATA_W-1:0] i_data_wdata,
    input  logic                   i_inst_req,
    input  soc_pkg::soc_addr_t     i_inst_addr,
    input  logic [`SOC_DATA_W-1:0] i_ram_data_in,
    input  logic [`SOC_INST_W-1:0] i_inst_data_in,
    output logic                   o_data_ok,
    output logic [`SOC_DATA_W-1:0] o_data_rdata,
    output logic                   o_inst_ok,
    output logic [`SOC_INST_W-1:0] o_inst_rdata,
    output logic                   o_read_ram_ena,
    output logic                   o_read_inst_ena,
    output soc_pkg::soc_addr_t     o_addr_outp,
    output logic                   o_write_ram_ena,
    output soc_pkg::soc_addr_t     o_write_ram_addr,
    output logic [`SOC_DATA_W-1:0] o_write_ram_data
);
    import soc_pkg::*;

    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_READ  = 3'd1;
    localparam logic [2:0] S_CAPT  = 3'd2;
    localparam logic [2:0] S_WRITE = 3'd3;
    localparam logic [2:0] S_WACK  = 3'd4;

    logic [2:0]             state_q;
    logic [2:0]             state_d;
    logic                   gnt_data_q;
    logic                   data_req;
    soc_addr_t              addr_q;
    logic [`SOC_DATA_W-1:0] wdata_q;

    assign data_req = i_data_re || i_data_we;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (i_data_we) begin
                    state_d = S_WRITE;
                end else if (i_data_re || i_inst_req) begin
                    state_d = S_READ;
                end
            end
            S_READ:  state_d = S_CAPT;
            S_WRITE: state_d = S_WACK;
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_q    <= S_IDLE;
            gnt_data_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == S_IDLE) begin
                gnt_data_q <= data_req;
            end
        end
    end

    // winner's address and write word, held for the whole access
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE) begin
            addr_q  <= data_req ? i_data_addr : i_inst_addr;
            wdata_q <= i_data_wdata;
        end
    end

    assign o_read_ram_ena   = (state_q == S_READ) && gnt_data_q;
    assign o_read_inst_ena  = (state_q == S_READ) && !gnt_data_q;
    assign o_write_ram_ena  = (state_q == S_WRITE);
    assign o_addr_outp      = addr_q;
    assign o_write_ram_addr = addr_q;
    assign o_write_ram_data = wdata_q;

    // ok falls in the capture cycle, the requester registers the word
    assign o_data_ok    = gnt_data_q && ((state_q == S_CAPT) || (state_q == S_WACK));
    assign o_inst_ok    = !gnt_data_q && (state_q == S_CAPT);
    assign o_data_rdata = i_ram_data_in;
    assign o_inst_rdata = i_inst_data_in;

endmodule

// ==== hdl/soc_mem_top.sv ====
// --------------------------------------------------
// memory side of the SoC: icache, data router,
// machine timer and the shared RAM port arbiter
// RAM never stalls; all writes are full 64-bit words
// --------------------------------------------------

`include "soc_consts.svh"

module soc_mem_top (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_inst_ena,
    input  soc_pkg::icache_addr_u  i_inst_addr,
    input  logic                   i_data_re,
    input  logic                   i_data_we,
    input  soc_pkg::soc_addr_t     i_data_addr,
    input  logic [`SOC_DATA_W-1:0] i_data_wdata,
    input  logic [`SOC_INST_W-1:0] i_inst_data_in,
    input  logic [`SOC_DATA_W-1:0] i_ram_data_in,
    output logic [`SOC_INST_W-1:0] o_inst,
    output logic                   o_inst_valid,
    output logic [`SOC_DATA_W-1:0] o_data_rdata,
    output logic                   o_mem_finish,
    output logic                   o_timer_intr,
    output logic                   o_read_ram_ena,
    output logic                   o_read_inst_ena,
    output soc_pkg::soc_addr_t     o_addr_outp,
    output logic                   o_write_ram_ena,
    output soc_pkg::soc_addr_t     o_write_ram_addr,
    output logic [`SOC_DATA_W-1:0] o_write_ram_data
);
    import soc_pkg::*;

    // fetch refill pair
    logic                   refill_req;
    soc_addr_t              refill_addr;
    logic                   inst_ok;
    logic [`SOC_INST_W-1:0] inst_rdata;

    // data RAM pair
    logic                   ram_re;
    logic                   ram_we;
    soc_addr_t              ram_addr;
    logic [`SOC_DATA_W-1:0] ram_wdata;
    logic                   data_ok;
    logic [`SOC_DATA_W-1:0] data_rdata;

    // timer registers
    logic                   tmr_we;
    logic                   tmr_sel;
    logic [`SOC_DATA_W-1:0] tmr_wdata;
    logic [`SOC_DATA_W-1:0] tmr_rdata;

    icache icache_i (
        .clk(clk), .i_reset(i_reset),
        .i_inst_ena(i_inst_ena), .i_inst_addr(i_inst_addr),
        .i_refill_ok(inst_ok), .i_refill_data(inst_rdata),
        .o_inst(o_inst), .o_inst_valid(o_inst_valid),
        .o_refill_req(refill_req), .o_refill_addr(refill_addr)
    );

    dmem_router dmem_router_i (
        .clk(clk), .i_reset(i_reset),
        .i_data_re(i_data_re), .i_data_we(i_data_we),
        .i_data_addr(i_data_addr), .i_data_wdata(i_data_wdata),
        .i_ram_ok(data_ok), .i_ram_rdata(data_rdata), .i_tmr_rdata(tmr_rdata),
        .o_ram_re(ram_re), .o_ram_we(ram_we),
        .o_ram_addr(ram_addr), .o_ram_wdata(ram_wdata),
        .o_tmr_we(tmr_we), .o_tmr_sel(tmr_sel), .o_tmr_wdata(tmr_wdata),
        .o_data_rdata(o_data_rdata), .o_mem_finish(o_mem_finish)
    );

    clint_timer clint_timer_i (
        .clk(clk), .i_reset(i_reset),
        .i_tmr_we(tmr_we), .i_tmr_sel(tmr_sel), .i_tmr_wdata(tmr_wdata),
        .o_tmr_rdata(tmr_rdata), .o_timer_intr(o_timer_intr)
    );

    mem_arbiter mem_arbiter_i (
        .clk(clk), .i_reset(i_reset),
        .i_data_re(ram_re), .i_data_we(ram_we),
        .i_data_addr(ram_addr), .i_data_wdata(ram_wdata),
        .i_inst_req(refill_req), .i_inst_addr(refill_addr),
        .i_ram_data_in(i_ram_data_in), .i_inst_data_in(i_inst_data_in),
        .o_data_ok(data_ok), .o_data_rdata(data_rdata),
        .o_inst_ok(inst_ok), .o_inst_rdata(inst_rdata),
        .o_read_ram_ena(o_read_ram_ena), .o_read_inst_ena(o_read_inst_ena),
        .o_addr_outp(o_addr_outp), .o_write_ram_ena(o_write_ram_ena),
        .o_write_ram_addr(o_write_ram_addr), .o_write_ram_data(o_write_ram_data)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
// --------------------------------------------------
// free-running testbench clock and reset
// reset high for RESET_CYCLES rising edges
// --------------------------------------------------

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 5
) (
    output logic o_clk,
    output logic o_reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // released on an edge, like every other input
    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_reset <= 1'b0;
    end

endmodule

// ==== tb/tb_soc_mem.sv ====
// --------------------------------------------------
// testbench for soc_mem_top with a fixed-latency RAM model
// unwritten RAM words are a hash of the address
// every wait gives up after WAIT_LIMIT cycles
// --------------------------------------------------

`include "soc_consts.svh"

module tb_soc_mem;
    timeunit 1ns;
    timeprecision 1ps;
    import soc_pkg::*;

    localparam logic [31:0] SEED       = 32'h0bfa41d8;
    localparam int          WAIT_LIMIT = 200;
    localparam soc_addr_t   FETCH_A    = 64'h0000_0000_8000_0100;
    localparam soc_addr_t   FETCH_B    = 64'h0000_0000_8000_0244;
    localparam soc_addr_t   RAM_A      = 64'h0000_0000_8001_0008;
    localparam soc_addr_t   RAM_B      = 64'h0000_0000_8002_0010;
    localparam soc_addr_t   RAM_C      = 64'h0000_0000_8003_0018;

    logic clk, i_reset, i_inst_ena, i_data_re, i_data_we;
    icache_addr_u           i_inst_addr;
    soc_addr_t              i_data_addr, o_addr_outp, o_write_ram_addr;
    logic [`SOC_DATA_W-1:0] i_data_wdata, i_ram_data_in, o_data_rdata, o_write_ram_data;
    logic [`SOC_INST_W-1:0] i_inst_data_in, o_inst;
    logic o_inst_valid, o_mem_finish, o_timer_intr;
    logic o_read_ram_ena, o_read_inst_ena, o_write_ram_ena;

    tb_clock_gen clock_gen_i (.o_clk(clk), .o_reset(i_reset));
    soc_mem_top dut_i (.*);

    // RAM model state and bus monitors
    logic [63:0] ram_words [logic [63:0]];
    logic [63:0] rd_word;
    soc_addr_t   last_wr_addr;
    logic [63:0] last_wr_data;
    int errors = 0, err_mark = 0, tests_run = 0, tests_failed = 0;
    int cycle = 0, inst_rd_count = 0, ram_en_count = 0;
    int last_ram_rd_cycle = 0, last_inst_rd_cycle = 0;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    function automatic logic [63:0] model_word(input soc_addr_t addr);
        logic [31:0] lo;
        if (ram_words.exists(addr)) begin
            return ram_words[addr];
        end
        lo = xorshift32(addr[31:0] ^ SEED);
        return {xorshift32(lo ^ addr[63:32] ^ {SEED[15:0], SEED[31:16]}), lo};
    endfunction

    always @(posedge clk) begin
        if (!i_reset) begin
            cycle <= cycle + 1;
            if (o_write_ram_ena) begin
                ram_words[o_write_ram_addr] = o_write_ram_data;
                last_wr_addr <= o_write_ram_addr;
                last_wr_data <= o_write_ram_data;
            end
            // data due one cycle after the enable
            if (o_read_ram_ena || o_read_inst_ena) begin
                rd_word = model_word(o_addr_outp);
                i_ram_data_in  <= rd_word;
                i_inst_data_in <= rd_word[31:0];
            end
            if (o_read_ram_ena) begin
                last_ram_rd_cycle <= cycle;
            end
            if (o_read_inst_ena) begin
                last_inst_rd_cycle <= cycle;
                inst_rd_count      <= inst_rd_count + 1;
            end
            if (o_read_ram_ena || o_read_inst_ena || o_write_ram_ena) begin
                ram_en_count <= ram_en_count + 1;
            end
        end
    end

    a_one_read: assert property (@(posedge clk) disable iff (i_reset)
        !(o_read_ram_ena && o_read_inst_ena))
        else begin
            errors++;
            $display("data and fetch read enables were high in the same cycle");
        end
    a_valid_pulse: assert property (@(posedge clk) disable iff (i_reset)
        o_inst_valid |=> !o_inst_valid)
        else begin
            errors++;
            $display("o_inst_valid stayed high for more than one cycle");
        end
    a_finish_pulse: assert property (@(posedge clk) disable iff (i_reset)
        o_mem_finish |=> !o_mem_finish)
        else begin
            errors++;
            $display("o_mem_finish stayed high for more than one cycle");
        end

    task automatic check_value(input string test, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        assert (actual === expected)
        else begin
            errors++;
            $display("[FAIL] %s %s expected %h actual %h", test, what, expected, actual);
        end
    endtask

    task automatic end_test(input string test);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s: passed", test);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // hold the fetch until o_inst_valid
    task automatic fetch(input string test, input soc_addr_t addr,
                         output logic [31:0] inst);
        int n;
        bit done;
        n    = 0;
        done = 0;
        inst = 'x;
        @(posedge clk);
        i_inst_ena      <= 1'b1;
        i_inst_addr.raw <= addr;
        while (!done && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
            if (o_inst_valid) begin
                done = 1;
                inst = o_inst;
            end
        end
        i_inst_ena <= 1'b0;
        assert (done)
        else begin
            errors++;
            $display("%s: fetch got no o_inst_valid within %0d cycles", test, WAIT_LIMIT);
        end
    endtask

    // hold a data read or write until o_mem_finish
    task automatic data_access(input string test, input bit write, input soc_addr_t addr,
                               input logic [63:0] wdata, output logic [63:0] rdata);
        int n;
        bit done;
        n     = 0;
        done  = 0;
        rdata = 'x;
        @(posedge clk);
        i_data_re    <= !write;
        i_data_we    <= write;
        i_data_addr  <= addr;
        i_data_wdata <= wdata;
        while (!done && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
            if (o_mem_finish) begin
                done  = 1;
                rdata = o_data_rdata;
            end
        end
        i_data_re <= 1'b0;
        i_data_we <= 1'b0;
        assert (done)
        else begin
            errors++;
            $display("%s: data access got no o_mem_finish within %0d cycles", test, WAIT_LIMIT);
        end
    endtask

    task automatic wait_intr(input string test, input logic level);
        int n;
        n = 0;
        while (o_timer_intr !== level && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        assert (o_timer_intr === level)
        else begin
            errors++;
            $display("%s: o_timer_intr did not go to %b in time", test, level);
        end
    endtask

    initial begin
        logic [31:0] inst_a, inst_b;
        logic [63:0] rdata, t0, t1;
        int mark;
        i_inst_ena      = 1'b0;
        i_inst_addr     = '0;
        i_data_re       = 1'b0;
        i_data_we       = 1'b0;
        i_data_addr     = '0;
        i_data_wdata    = '0;
        i_ram_data_in   = '0;
        i_inst_data_in  = '0;
        mark = 0;
        while (i_reset !== 1'b0 && mark < WAIT_LIMIT) begin
            @(posedge clk);
            mark++;
        end
        assert (i_reset === 1'b0)
        else begin
            errors++;
            $display("reset: reset was not released within %0d cycles", WAIT_LIMIT);
        end
        check_value("reset", "enables and pulses", 6'b0, {o_read_ram_ena, o_read_inst_ena,
                    o_write_ram_ena, o_inst_valid, o_mem_finish, o_timer_intr});
        end_test("reset");

        // miss fills the entry so the repeat must hit
        fetch("fetch", FETCH_A, inst_a);
        t0 = model_word(FETCH_A);
        check_value("fetch", "miss word", t0[31:0], inst_a);
        mark = inst_rd_count;
        fetch("fetch", FETCH_A, inst_b);
        check_value("fetch", "hit word", t0[31:0], inst_b);
        check_value("fetch", "fetch reads on hit", 0, inst_rd_count - mark);
        end_test("fetch");

        data_access("ram_write", 1'b1, RAM_A, 64'hdead_beef_0123_4567, rdata);
        check_value("ram_write", "write addr", RAM_A, last_wr_addr);
        check_value("ram_write", "write data", 64'hdead_beef_0123_4567, last_wr_data);
        data_access("ram_write", 1'b0, RAM_A, '0, rdata);
        check_value("ram_write", "read back", 64'hdead_beef_0123_4567, rdata);
        end_test("ram_write");

        data_access("ram_read", 1'b0, RAM_B, '0, rdata);
        check_value("ram_read", "unwritten word", model_word(RAM_B), rdata);
        end_test("ram_read");

        mark = ram_en_count;
        data_access("timer_regs", 1'b0, `SOC_MTIMECMP_ADDR, '0, rdata);
        check_value("timer_regs", "mtimecmp reset", '1, rdata);
        data_access("timer_regs", 1'b1, `SOC_MTIMECMP_ADDR, 64'h0000_0123_4567_89ab, rdata);
        data_access("timer_regs", 1'b0, `SOC_MTIMECMP_ADDR, '0, rdata);
        check_value("timer_regs", "mtimecmp", 64'h0000_0123_4567_89ab, rdata);
        data_access("timer_regs", 1'b0, `SOC_MTIME_ADDR, '0, t0);
        data_access("timer_regs", 1'b0, `SOC_MTIME_ADDR, '0, t1);
        assert (t1 > t0)
        else begin
            errors++;
            $display("timer_regs: mtime did not increase, %h then %h", t0, t1);
        end
        check_value("timer_regs", "RAM enable cycles", 0, ram_en_count - mark);
        end_test("timer_regs");

        data_access("timer_intr", 1'b0, `SOC_MTIME_ADDR, '0, t0);
        data_access("timer_intr", 1'b1, `SOC_MTIMECMP_ADDR, t0 + 64'd20, rdata);
        wait_intr("timer_intr", 1'b1);
        data_access("timer_intr", 1'b1, `SOC_MTIMECMP_ADDR, '1, rdata);
        wait_intr("timer_intr", 1'b0);
        end_test("timer_intr");

        // data read raised as the fetch miss reaches the arbiter
        mark = cycle;
        fork
            fetch("arbitration", FETCH_B, inst_a);
            begin
                @(posedge clk);
                data_access("arbitration", 1'b0, RAM_C, '0, rdata);
            end
        join
        t0 = model_word(FETCH_B);
        check_value("arbitration", "fetch word", t0[31:0], inst_a);
        check_value("arbitration", "data word", model_word(RAM_C), rdata);
        assert (last_ram_rd_cycle >= mark && last_ram_rd_cycle < last_inst_rd_cycle)
        else begin
            errors++;
            $display("arbitration: o_read_ram_ena did not come before o_read_inst_ena");
        end
        end_test("arbitration");

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/soc_pkg.sv
hdl/icache.sv
hdl/dmem_router.sv
hdl/clint_timer.sv
hdl/mem_arbiter.sv
hdl/soc_mem_top.sv
tb/tb_clock_gen.sv
tb/tb_soc_mem.sv
